//--- common/nppCfg.svh
// Build-time sizes for the next-PC predictor
// Include wherever address, stack or table widths are needed

`ifndef NPP_CFG_SVH
`define NPP_CFG_SVH

// Instruction address width in bits
`define NPP_ADDR_W 32

// Return stack holds 2**RAS_DEPTH_LOG2 entries
`define RAS_DEPTH_LOG2 4

// Branch target buffer holds 2**BTB_INDEX_W entries
`define BTB_INDEX_W 6

`endif

//--- common/nppPkg.sv
// Shared types of the next-PC predictor
// Imported by every RTL module and by the testbench

`default_nettype none

`include "nppCfg.svh"

package nppPkg;

    // One instruction address
    typedef logic [`NPP_ADDR_W-1:0] addrT;

    // Kind of control transfer stored in a table entry
    typedef enum logic [1:0] {
        kindCond = 2'd0,
        kindJump = 2'd1,
        kindCall = 2'd2,
        kindRet  = 2'd3
    } branchKindT;

    // Saturating direction counter that predicts taken at 2 or 3
    typedef logic [1:0] counterT;

    // Origin of the predicted next PC
    typedef enum logic [1:0] {
        srcSeq   = 2'd0,
        srcBtb   = 2'd1,
        srcStack = 2'd2
    } predSourceT;

endpackage

`default_nettype wire

//--- common/btbLookupIf.sv
// Lookup result of the branch target buffer for the current fetch PC
// Driven by the buffer, read by the next-PC selector in the same cycle

`timescale 1ns/1ps
`default_nettype none

interface btbLookupIf import nppPkg::*; ();

    logic       hit;
    branchKindT kind;
    logic       taken;
    addrT       target;

    modport provider (
        output hit,
        output kind,
        output taken,
        output target
    );

    modport user (
        input hit,
        input kind,
        input taken,
        input target
    );

endinterface

`default_nettype wire

//--- common/btbUpdateIf.sv
// Resolved-branch update into the branch target buffer
// One update per cycle with valid high

`timescale 1ns/1ps
`default_nettype none

interface btbUpdateIf import nppPkg::*; ();

    logic       valid;
    addrT       pc;
    addrT       target;
    logic       taken;
    branchKindT kind;

    modport source (
        output valid,
        output pc,
        output target,
        output taken,
        output kind
    );

    modport sink (
        input valid,
        input pc,
        input target,
        input taken,
        input kind
    );

endinterface

`default_nettype wire

//--- returnStack/returnStack.sv
// Circular return address stack with one speculation checkpoint
// Flush restores pointer and count only and leaves overwritten slots as they are

`timescale 1ns/1ps
`default_nettype none

`include "nppCfg.svh"

module returnStack import nppPkg::*; #(
    parameter int DEPTH_LOG2 = `RAS_DEPTH_LOG2
) (
    input  wire       clk,
    input  wire       rstn,
    input  wire       push,
    input  wire addrT pushAddr,
    input  wire       pop,
    input  wire       speculate,
    input  wire       flush,
    output logic      empty,
    output addrT      top
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    addrT                  stackMem [DEPTH];
    logic [DEPTH_LOG2-1:0] ptr;
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2:0]   count;
    logic [DEPTH_LOG2-1:0] savePtr;
    logic [DEPTH_LOG2:0]   saveCount;
    logic                  ckptValid;

    assign empty = (count == '0);
    assign top   = stackMem[ptr];

    // Push with pop replaces the top while push alone goes one slot up
    assign wrPtr = pop ? ptr : ptr + 1'b1;

    //////////////////////////////////////////////////
    // Pointer, count and checkpoint
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ptr       <= '0;
            count     <= '0;
            savePtr   <= '0;
            saveCount <= '0;
            ckptValid <= 1'b0;
        end else if (flush) begin
            // Flush beats any push or pop
            ptr       <= savePtr;
            count     <= saveCount;
            ckptValid <= 1'b0;
        end else begin
            if (speculate && !ckptValid) begin
                savePtr   <= ptr;
                saveCount <= count;
                ckptValid <= 1'b1;
            end
            if (push && !pop) begin
                ptr <= ptr + 1'b1;
                if (!count[DEPTH_LOG2]) begin
                    count <= count + 1'b1;
                end
            end else if (pop && !push) begin
                ptr <= ptr - 1'b1;
                if (count != '0) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (rstn && !flush && push) begin
            stackMem[wrPtr] <= pushAddr;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    countBound: assert property (@(posedge clk) disable iff (!rstn)
        count <= DEPTH)
        else $error("return stack count above depth");

    flushDropsCkpt: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> !ckptValid)
        else $error("checkpoint still held after flush");

endmodule

`default_nettype wire

//--- branchTargetBuffer/branchTargetBuffer.sv
// Direct-mapped branch target and direction table
// Combinational lookup on the fetch PC, train or allocate on update

`timescale 1ns/1ps
`default_nettype none

`include "nppCfg.svh"

module branchTargetBuffer import nppPkg::*; #(
    parameter int INDEX_W = `BTB_INDEX_W
) (
    input  wire          clk,
    input  wire          rstn,
    input  wire addrT    fetchPc,
    btbLookupIf.provider lookup,
    btbUpdateIf.sink     update
);

    localparam int ENTRIES = 1 << INDEX_W;
    localparam int TAG_W   = `NPP_ADDR_W - INDEX_W - 2;

    logic [ENTRIES-1:0] validQ;
    logic [TAG_W-1:0]   tagMem    [ENTRIES];
    addrT               targetMem [ENTRIES];
    branchKindT         kindMem   [ENTRIES];
    counterT            ctrMem    [ENTRIES];

    logic [INDEX_W-1:0] rdIdx;
    logic [TAG_W-1:0]   rdTag;
    logic               rdHit;
    logic [INDEX_W-1:0] wrIdx;
    logic [TAG_W-1:0]   wrTag;
    logic               wrHit;

    // Step the counter one place toward the outcome
    function automatic counterT trainCounter(input counterT ctr, input logic taken);
        counterT nextCtr;
        nextCtr = ctr;
        if (taken && ctr != 2'd3) begin
            nextCtr = ctr + 2'd1;
        end else if (!taken && ctr != 2'd0) begin
            nextCtr = ctr - 2'd1;
        end
        return nextCtr;
    endfunction

    //////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////
    // Bits 1:0 are always zero for word-aligned fetch
    assign rdIdx = fetchPc[INDEX_W+1:2];
    assign rdTag = fetchPc[`NPP_ADDR_W-1:INDEX_W+2];
    assign rdHit = validQ[rdIdx] && (tagMem[rdIdx] == rdTag);

    assign lookup.hit    = rdHit;
    assign lookup.kind   = kindMem[rdIdx];
    assign lookup.target = targetMem[rdIdx];
    // Only conditional entries consult the counter
    assign lookup.taken  = rdHit && (kindMem[rdIdx] != kindCond || ctrMem[rdIdx][1]);

    //////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////
    assign wrIdx = update.pc[INDEX_W+1:2];
    assign wrTag = update.pc[`NPP_ADDR_W-1:INDEX_W+2];
    assign wrHit = validQ[wrIdx] && (tagMem[wrIdx] == wrTag);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            validQ <= '0;
        end else if (update.valid && !wrHit && update.taken) begin
            validQ[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            if (wrHit) begin
                targetMem[wrIdx] <= update.target;
                kindMem[wrIdx]   <= update.kind;
                ctrMem[wrIdx]    <= trainCounter(ctrMem[wrIdx], update.taken);
            end else if (update.taken) begin
                // Miss allocates only on taken, evicting whatever was there
                tagMem[wrIdx]    <= wrTag;
                targetMem[wrIdx] <= update.target;
                kindMem[wrIdx]   <= update.kind;
                ctrMem[wrIdx]    <= 2'd2;
            end
        end
    end

    updKindKnown: assert property (@(posedge clk) disable iff (!rstn)
        update.valid |-> !$isunknown(update.kind))
        else $error("update kind unknown while update valid");

endmodule

`default_nettype wire

//--- verilog/nextPcPredictor.sv
// Next-PC predictor top level with plain ports
// Ties the target buffer and return stack to the selector

`timescale 1ns/1ps
`default_nettype none

`include "nppCfg.svh"

module nextPcPredictor import nppPkg::*; (
    input  wire              clk,
    input  wire              rstn,
    input  wire              fetchValid,
    input  wire addrT        fetchPc,
    input  wire              updValid,
    input  wire addrT        updPc,
    input  wire addrT        updTarget,
    input  wire              updTaken,
    input  wire branchKindT  updKind,
    input  wire              speculate,
    input  wire              flush,
    output addrT             predPc,
    output logic             predTaken,
    output predSourceT       predSource
);

    btbLookupIf lookupBus ();
    btbUpdateIf updateBus ();

    logic push;
    logic pop;
    addrT pushAddr;
    logic stackEmpty;
    addrT stackTop;

    // Resolution port onto the update bus
    assign updateBus.valid  = updValid;
    assign updateBus.pc     = updPc;
    assign updateBus.target = updTarget;
    assign updateBus.taken  = updTaken;
    assign updateBus.kind   = updKind;

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////
    branchTargetBuffer #(
        .INDEX_W (`BTB_INDEX_W)
    ) uBtb (
        .clk     (clk),
        .rstn    (rstn),
        .fetchPc (fetchPc),
        .lookup  (lookupBus.provider),
        .update  (updateBus.sink)
    );

    returnStack #(
        .DEPTH_LOG2 (`RAS_DEPTH_LOG2)
    ) uStack (
        .clk       (clk),
        .rstn      (rstn),
        .push      (push),
        .pushAddr  (pushAddr),
        .pop       (pop),
        .speculate (speculate),
        .flush     (flush),
        .empty     (stackEmpty),
        .top       (stackTop)
    );

    nextPcSelect uSelect (
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid),
        .lookup     (lookupBus.user),
        .stackEmpty (stackEmpty),
        .stackTop   (stackTop),
        .push       (push),
        .pushAddr   (pushAddr),
        .pop        (pop),
        .predPc     (predPc),
        .predTaken  (predTaken),
        .predSource (predSource)
    );

endmodule

`default_nettype wire

//--- verilog/nextPcSelect.sv
// Picks the next fetch PC from the table lookup and the stack top
// Also raises push on call hits and pop on ret hits

`timescale 1ns/1ps
`default_nettype none

module nextPcSelect import nppPkg::*; (
    input  wire addrT  fetchPc,
    input  wire        fetchValid,
    btbLookupIf.user   lookup,
    input  wire        stackEmpty,
    input  wire addrT  stackTop,
    output logic       push,
    output addrT       pushAddr,
    output logic       pop,
    output addrT       predPc,
    output logic       predTaken,
    output predSourceT predSource
);

    addrT seqPc;

    assign seqPc = fetchPc + addrT'(4);

    // Stack activity only for a real fetch
    assign push     = fetchValid && lookup.hit && (lookup.kind == kindCall);
    assign pop      = fetchValid && lookup.hit && (lookup.kind == kindRet);
    assign pushAddr = seqPc;

    always_comb begin
        predPc     = seqPc;
        predTaken  = 1'b0;
        predSource = srcSeq;
        if (lookup.hit) begin
            case (lookup.kind)
                kindRet: begin
                    predTaken = 1'b1;
                    if (!stackEmpty) begin
                        predPc     = stackTop;
                        predSource = srcStack;
                    end else begin
                        // Empty stack falls back to the stored target
                        predPc     = lookup.target;
                        predSource = srcBtb;
                    end
                end
                kindCall, kindJump: begin
                    predPc     = lookup.target;
                    predTaken  = 1'b1;
                    predSource = srcBtb;
                end
                kindCond: begin
                    if (lookup.taken) begin
                        predPc     = lookup.target;
                        predTaken  = 1'b1;
                        predSource = srcBtb;
                    end
                end
            endcase
        end
        srcStackOnRet: assert (predSource != srcStack
                               || (lookup.hit && lookup.kind == kindRet))
            else $error("stack source without a ret hit");
    end

endmodule

`default_nettype wire

//--- bench/nextPcPredictorTb.sv
// Self-checking testbench for the next-PC predictor
// Drives directed and random fetch, update and flush traffic against a reference model

`timescale 1ns/1ps
`default_nettype none

`include "nppCfg.svh"

module nextPcPredictorTb import nppPkg::*; ();

    localparam int TBL_SIZE   = 1 << `BTB_INDEX_W;
    localparam int RAS_SIZE   = 1 << `RAS_DEPTH_LOG2;
    localparam int MAX_CYCLES = 5000;

    logic       clk;
    logic       rstn;
    logic       fetchValid;
    addrT       fetchPc;
    logic       updValid;
    addrT       updPc;
    addrT       updTarget;
    logic       updTaken;
    branchKindT updKind;
    logic       speculate;
    logic       flush;
    addrT       predPc;
    logic       predTaken;
    predSourceT predSource;

    // Reference model of the table and the stack
    logic       mValid  [TBL_SIZE];
    addrT       mTag    [TBL_SIZE];
    addrT       mTarget [TBL_SIZE];
    branchKindT mKind   [TBL_SIZE];
    int         mCtr    [TBL_SIZE];
    addrT       mStack  [RAS_SIZE];
    int         mPtr;
    int         mCount;
    int         mSavePtr;
    int         mSaveCount;
    logic       mCkpt;

    int   checkCount;
    int   errorCount;
    int   cycleCount;
    int   testNum;
    int   testChecks;
    int   testErrors;
    logic specLevel;

    nextPcPredictor DUT (
        .clk        (clk),
        .rstn       (rstn),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .updValid   (updValid),
        .updPc      (updPc),
        .updTarget  (updTarget),
        .updTaken   (updTaken),
        .updKind    (updKind),
        .speculate  (speculate),
        .flush      (flush),
        .predPc     (predPc),
        .predTaken  (predTaken),
        .predSource (predSource)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic int tblIndex(input addrT pc);
        return int'((pc >> 2) % TBL_SIZE);
    endfunction

    function automatic addrT tagOf(input addrT pc);
        return pc >> (`BTB_INDEX_W + 2);
    endfunction

    function automatic void refPredict(input addrT pc, output addrT expPc,
                                       output logic expTaken, output predSourceT expSrc);
        int   idx;
        logic hit;
        idx      = tblIndex(pc);
        hit      = mValid[idx] && (mTag[idx] == tagOf(pc));
        expPc    = pc + 32'd4;
        expTaken = 1'b0;
        expSrc   = srcSeq;
        if (hit && mKind[idx] == kindRet) begin
            expTaken = 1'b1;
            if (mCount != 0) begin
                expPc  = mStack[mPtr];
                expSrc = srcStack;
            end else begin
                expPc  = mTarget[idx];
                expSrc = srcBtb;
            end
        end else if (hit && (mKind[idx] != kindCond || mCtr[idx] >= 2)) begin
            expPc    = mTarget[idx];
            expTaken = 1'b1;
            expSrc   = srcBtb;
        end
    endfunction

    task automatic modelReset;
        for (int i = 0; i < TBL_SIZE; i++) begin
            mValid[i] = 1'b0;
        end
        mPtr       = 0;
        mCount     = 0;
        mSavePtr   = 0;
        mSaveCount = 0;
        mCkpt      = 1'b0;
    endtask

    // Next state as seen after the coming rising edge
    task automatic modelAdvance;
        int   idx;
        logic hit;
        logic doPush;
        logic doPop;
        idx    = tblIndex(fetchPc);
        hit    = mValid[idx] && (mTag[idx] == tagOf(fetchPc));
        doPush = fetchValid && hit && mKind[idx] == kindCall;
        doPop  = fetchValid && hit && mKind[idx] == kindRet;
        if (flush) begin
            mPtr   = mSavePtr;
            mCount = mSaveCount;
            mCkpt  = 1'b0;
        end else begin
            if (speculate && !mCkpt) begin
                mSavePtr   = mPtr;
                mSaveCount = mCount;
                mCkpt      = 1'b1;
            end
            if (doPush && doPop) begin
                mStack[mPtr] = fetchPc + 32'd4;
            end else if (doPush) begin
                mPtr         = (mPtr + 1) % RAS_SIZE;
                mStack[mPtr] = fetchPc + 32'd4;
                if (mCount < RAS_SIZE) mCount++;
            end else if (doPop) begin
                mPtr = (mPtr + RAS_SIZE - 1) % RAS_SIZE;
                if (mCount > 0) mCount--;
            end
        end
        if (updValid) begin
            idx = tblIndex(updPc);
            if (mValid[idx] && mTag[idx] == tagOf(updPc)) begin
                mTarget[idx] = updTarget;
                mKind[idx]   = updKind;
                if (updTaken && mCtr[idx] < 3) mCtr[idx]++;
                else if (!updTaken && mCtr[idx] > 0) mCtr[idx]--;
            end else if (updTaken) begin
                mValid[idx]  = 1'b1;
                mTag[idx]    = tagOf(updPc);
                mTarget[idx] = updTarget;
                mKind[idx]   = updKind;
                mCtr[idx]    = 2;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic compareAddr(input addrT got, input addrT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t ns: predPc 0x%08h, expected 0x%08h at fetchPc 0x%08h",
                     $time, got, exp, fetchPc);
        end
    endtask

    task automatic compareTaken(input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t ns: predTaken %b, expected %b at fetchPc 0x%08h",
                     $time, got, exp, fetchPc);
        end
    endtask

    task automatic compareSource(input predSourceT got, input predSourceT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t ns: predSource %s, expected %s at fetchPc 0x%08h",
                     $time, got.name(), exp.name(), fetchPc);
        end
    endtask

    // Checks at mid-cycle while the inputs are stable
    always @(negedge clk) begin : modelCheck
        addrT       expPc;
        logic       expTaken;
        predSourceT expSrc;
        if (!rstn) begin
            modelReset();
        end else begin
            if (fetchValid) begin
                refPredict(fetchPc, expPc, expTaken, expSrc);
                compareAddr(predPc, expPc);
                compareTaken(predTaken, expTaken);
                compareSource(predSource, expSrc);
            end
            modelAdvance();
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic driveCycle(input logic fv, input addrT pc, input logic uv,
                              input addrT upc, input addrT utgt, input logic utk,
                              input branchKindT ukind, input logic fl);
        @(posedge clk);
        fetchValid <= fv;
        fetchPc    <= pc;
        updValid   <= uv;
        updPc      <= upc;
        updTarget  <= utgt;
        updTaken   <= utk;
        updKind    <= ukind;
        speculate  <= specLevel;
        flush      <= fl;
    endtask

    task automatic fetchAt(input addrT pc);
        driveCycle(1'b1, pc, 1'b0, '0, '0, 1'b0, kindCond, 1'b0);
    endtask

    task automatic trainEntry(input addrT pc, input addrT tgt, input logic tk,
                              input branchKindT kind);
        driveCycle(1'b0, '0, 1'b1, pc, tgt, tk, kind, 1'b0);
    endtask

    task automatic idleCycle;
        driveCycle(1'b0, '0, 1'b0, '0, '0, 1'b0, kindCond, 1'b0);
    endtask

    task automatic startTest;
        testNum++;
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        idleCycle();
        $display("Test %0d %s finished: %0d checks, %0d errors", testNum, name,
                 checkCount - testChecks, errorCount - testErrors);
    endtask

    function automatic addrT callPc(input int i);
        return 32'h0000_2000 + addrT'(i * 4);
    endfunction

    function automatic addrT randPc();
        return 32'h0000_4000 | (addrT'($urandom % 4) << 8) | (addrT'($urandom % 64) << 2);
    endfunction

    initial begin : stimulus
        addrT       condPc;
        addrT       retPc;
        logic       fl;
        logic       fv;
        logic       uv;
        branchKindT uk;
        void'($urandom(32'hb190));
        checkCount = 0;
        errorCount = 0;
        cycleCount = 0;
        testNum    = 0;
        specLevel  = 1'b0;
        rstn       = 1'b0;
        fetchValid = 1'b0;
        fetchPc    = '0;
        updValid   = 1'b0;
        updPc      = '0;
        updTarget  = '0;
        updTaken   = 1'b0;
        updKind    = kindCond;
        speculate  = 1'b0;
        flush      = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        startTest();
        for (int i = 0; i < 50; i++) fetchAt(addrT'($urandom) & ~addrT'(3));
        endTest("sequential fallthrough");

        startTest();
        condPc = 32'h0000_1000;
        trainEntry(condPc, 32'h0000_1800, 1'b0, kindCond);
        fetchAt(condPc);
        trainEntry(condPc, 32'h0000_1800, 1'b1, kindCond);
        fetchAt(condPc);
        repeat (2) trainEntry(condPc, 32'h0000_1800, 1'b0, kindCond);
        fetchAt(condPc);
        repeat (3) trainEntry(condPc, 32'h0000_1840, 1'b1, kindCond);
        fetchAt(condPc);
        // Extra taken updates hold the counter at 3 so two not-taken reach 1
        repeat (2) trainEntry(condPc, 32'h0000_1840, 1'b1, kindCond);
        repeat (2) trainEntry(condPc, 32'h0000_1840, 1'b0, kindCond);
        fetchAt(condPc);
        // Extra not-taken updates hold the counter at 0 so two taken reach 2
        repeat (3) trainEntry(condPc, 32'h0000_1840, 1'b0, kindCond);
        repeat (2) trainEntry(condPc, 32'h0000_1840, 1'b1, kindCond);
        fetchAt(condPc);
        // Same index under a different tag
        fetchAt(condPc + 32'h0000_0100);
        endTest("direction training");

        startTest();
        retPc = callPc(40);
        for (int i = 0; i < 20; i++) begin
            trainEntry(callPc(i), 32'h5000 + addrT'(i * 64), 1'b1, kindCall);
        end
        trainEntry(retPc, 32'h0000_7000, 1'b1, kindRet);
        for (int i = 0; i < 20; i++) fetchAt(callPc(i));
        repeat (18) fetchAt(retPc);
        endTest("call and return");

        startTest();
        for (int i = 0; i < 4; i++) fetchAt(callPc(i));
        specLevel = 1'b1;
        fetchAt(retPc);
        fetchAt(retPc);
        fetchAt(callPc(10));
        fetchAt(callPc(11));
        driveCycle(1'b1, callPc(5), 1'b0, '0, '0, 1'b0, kindCond, 1'b1);
        specLevel = 1'b0;
        repeat (6) fetchAt(retPc);
        endTest("speculation recovery");

        startTest();
        for (int i = 0; i < 1500; i++) begin
            fv = ($urandom % 100) < 80;
            uv = ($urandom % 100) < 30;
            uk = branchKindT'(2'($urandom));
            if (($urandom % 100) < 5) specLevel = !specLevel;
            fl = ($urandom % 100) < 3;
            driveCycle(fv, randPc(), uv, randPc(), addrT'($urandom) & ~addrT'(3),
                       1'($urandom), uk, fl);
        end
        endTest("random mix");

        idleCycle();
        $display("Done: %0d tests, %0d checks, %0d errors", testNum, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- nextPcPredictor.f
+incdir+common
common/nppPkg.sv
common/btbLookupIf.sv
common/btbUpdateIf.sv
returnStack/returnStack.sv
branchTargetBuffer/branchTargetBuffer.sv
verilog/nextPcPredictor.sv
verilog/nextPcSelect.sv
bench/nextPcPredictorTb.sv

//--- Makefile
# Verilator build and run for the next-PC predictor testbench
# Variables can be overridden on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= nextPcPredictorTb
FILELIST  ?= nextPcPredictor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** PASSED ***

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
